// ==== csi2_pkg.sv ====
`default_nettype none

package csi2_pkg;

  // one merged word from the lanes.
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } lane_word_t;

  // field layout of the low 30 bits of a header word.
  typedef struct packed {
    logic [5:0]  ecc;
    logic [15:0] wc;
    logic [1:0]  vc;
    logic [5:0]  dt;
  } pkt_header_t;

  typedef struct packed {
    logic [1:0]  vc;
    logic [5:0]  dt;
    logic [15:0] wc;
    logic        is_long;
    logic        ecc_err;
    logic        ecc_corrected;
    logic        crc_err;       // zero for short packets.
  } pkt_report_t;

  typedef enum logic [1:0] {
    IDLE,
    HDR_WAIT,
    PAYLOAD,
    CRC_WORD
  } trk_state_t;

  // data bits 23:0 feeding each of the six ecc parity bits.
  localparam logic [5:0][23:0] ECC_PAR_MASK = '{
    0: 24'hF12CB7,
    1: 24'hF2555B,
    2: 24'h749A6D,
    3: 24'hB8E38E,
    4: 24'hDF03F0,
    5: 24'hEFFC00
  };

  localparam logic [5:0]  LONG_DT_MIN   = 6'h10;
  localparam logic [15:0] CRC_POLY_REFL = 16'h8408;
  localparam logic [15:0] CRC_INIT      = 16'hFFFF;

  // 0..23 data bit in error, 30 parity bit in error, 31 uncorrectable.
  function automatic logic [4:0] ecc_bit_pos(input logic [5:0] syndrome);
    logic [4:0] pos;
    logic [5:0] column;
    pos = 5'd31;
    if (syndrome != 6'd0 && (syndrome & (syndrome - 6'd1)) == 6'd0)
      pos = 5'd30;
    for (int i = 0; i < 24; i++)
    begin
      for (int k = 0; k < 6; k++)
        column[k] = ECC_PAR_MASK[k][i];
      if (column == syndrome)
        pos = 5'(i);                // syndrome equals the column of bit i.
    end
    return pos;
  endfunction

endpackage

`default_nettype wire

// ==== csi2_hamming_dec.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_hamming_dec
(
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  csi2_pkg::lane_word_t word_i,
  input  logic                 pkt_done_i,
  output csi2_pkg::lane_word_t hdr_word_o,
  output logic                 err_o,
  output logic                 corrected_o
);

logic [5:0]  parity;
logic [5:0]  syndrome;
logic        valid_d;
logic [31:0] data_d;
logic        err_d;
logic [4:0]  pos_d;
logic        hdr_seen;
logic        first_hdr;
logic        out_valid;
logic [31:0] out_data;

always_comb
begin
  for (int k = 0; k < 6; k++)
    parity[k] = ^(word_i.data[23:0] & csi2_pkg::ECC_PAR_MASK[k]);
end

assign syndrome  = parity ^ word_i.data[29:24];
assign first_hdr = valid_d && !hdr_seen; // only the first word of a packet is a header.

// stage one.
always_ff @(posedge clk_i)
begin
  if (srst_i)
    valid_d <= 1'b0;
  else
    valid_d <= word_i.valid;
end

always_ff @(posedge clk_i)
begin
  data_d <= word_i.data;
  err_d  <= (syndrome != 6'd0);
  pos_d  <= csi2_pkg::ecc_bit_pos(syndrome);
end

always_ff @(posedge clk_i)
begin
  if (srst_i)
    hdr_seen <= 1'b0;
  else if (pkt_done_i)
    hdr_seen <= 1'b0;
  else if (first_hdr)
    hdr_seen <= 1'b1;
end

// flags hold until the packet ends.
always_ff @(posedge clk_i)
begin
  if (srst_i || pkt_done_i)
  begin
    err_o       <= 1'b0;
    corrected_o <= 1'b0;
  end
  else if (first_hdr && err_d)
  begin
    err_o       <= 1'b1;
    corrected_o <= (pos_d != 5'd31);
  end
end

// stage two.
always_ff @(posedge clk_i)
begin
  if (srst_i)
    out_valid <= 1'b0;
  else
    out_valid <= valid_d;
end

always_ff @(posedge clk_i)
begin
  out_data <= data_d;
  if (first_hdr && err_d && pos_d < 5'd24)
    out_data[pos_d] <= ~data_d[pos_d]; // parity bit errors leave the data alone.
end

assign hdr_word_o = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

// ==== csi2_crc_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_crc_chk
(
  input  logic                 clk_i,
  input  logic                 srst_i,
  input  csi2_pkg::lane_word_t word_i,
  input  logic                 payload_i,
  input  logic                 crc_word_i,
  input  logic                 pkt_done_i,
  output logic                 crc_done_o,
  output logic                 crc_err_o
);

logic [15:0] crc;

// reflected crc-16 over four bytes, bit 0 of the word first.
function automatic logic [15:0] crc_fold(input logic [15:0] crc_in,
                                         input logic [31:0] data);
  logic [15:0] acc;
  logic        fb;
  acc = crc_in;
  for (int i = 0; i < 32; i++)
  begin
    fb  = acc[0] ^ data[i];
    acc = acc >> 1;
    if (fb)
      acc = acc ^ csi2_pkg::CRC_POLY_REFL;
  end
  return acc;
endfunction

always_ff @(posedge clk_i)
begin
  if (srst_i)
    crc <= csi2_pkg::CRC_INIT;
  else if (pkt_done_i)
    crc <= csi2_pkg::CRC_INIT;  // re-arm for the next packet.
  else if (payload_i)
    crc <= crc_fold(crc, word_i.data);
end

always_ff @(posedge clk_i)
begin
  if (srst_i)
    crc_done_o <= 1'b0;
  else
    crc_done_o <= crc_word_i;
end

always_ff @(posedge clk_i)
begin
  if (crc_word_i)
    crc_err_o <= (crc != word_i.data[15:0]); // no final xor.
end

endmodule

`default_nettype wire

// ==== csi2_pkt_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_pkt_tracker
(
  input  logic                  clk_i,
  input  logic                  srst_i,
  input  csi2_pkg::lane_word_t  word_i,
  input  csi2_pkg::lane_word_t  hdr_word_i,
  input  logic                  ecc_err_i,
  input  logic                  ecc_corrected_i,
  input  logic                  crc_done_i,
  input  logic                  crc_err_i,
  output logic                  payload_o,
  output logic                  crc_word_o,
  output logic                  pkt_done_o,
  output logic                  report_valid_o,
  output csi2_pkg::pkt_report_t report_o
);

csi2_pkg::trk_state_t  state;
csi2_pkg::pkt_header_t hdr;
logic [13:0]           words_left;
logic                  hdr_long;
logic                  hdr_take;

assign hdr      = csi2_pkg::pkt_header_t'(hdr_word_i.data[29:0]);
assign hdr_long = (hdr.dt >= csi2_pkg::LONG_DT_MIN);
assign hdr_take = (state == csi2_pkg::HDR_WAIT) && hdr_word_i.valid;

assign payload_o  = (state == csi2_pkg::PAYLOAD) && word_i.valid;
assign crc_word_o = (state == csi2_pkg::CRC_WORD) && word_i.valid;
assign pkt_done_o = report_valid_o; // the report also re-arms both checkers.

always_ff @(posedge clk_i)
begin
  if (srst_i)
  begin
    state          <= csi2_pkg::IDLE;
    words_left     <= '0;
    report_valid_o <= 1'b0;
  end
  else
  begin
    report_valid_o <= 1'b0;
    case (state)
      csi2_pkg::IDLE:
        if (word_i.valid)
          state <= csi2_pkg::HDR_WAIT;
      csi2_pkg::HDR_WAIT:
        if (hdr_word_i.valid)
        begin
          words_left <= hdr.wc[15:2];
          if (!hdr_long)
          begin
            report_valid_o <= 1'b1;
            state          <= csi2_pkg::IDLE;
          end
          else if (hdr.wc[15:2] == 14'd0)
            state <= csi2_pkg::CRC_WORD;
          else
            state <= csi2_pkg::PAYLOAD;
        end
      csi2_pkg::PAYLOAD:
        if (word_i.valid)
        begin
          words_left <= words_left - 14'd1;
          if (words_left == 14'd1)
            state <= csi2_pkg::CRC_WORD;
        end
      csi2_pkg::CRC_WORD:
        if (crc_done_i)             // crc word was the cycle before.
        begin
          report_valid_o <= 1'b1;
          state          <= csi2_pkg::IDLE;
        end
      default:
        state <= csi2_pkg::IDLE;
    endcase
  end
end

always_ff @(posedge clk_i)
begin
  if (hdr_take)
  begin
    report_o.vc            <= hdr.vc;
    report_o.dt            <= hdr.dt;
    report_o.wc            <= hdr.wc;
    report_o.is_long       <= hdr_long;
    report_o.ecc_err       <= ecc_err_i;
    report_o.ecc_corrected <= ecc_corrected_i;
    report_o.crc_err       <= 1'b0;
  end
  else if (state == csi2_pkg::CRC_WORD && crc_done_i)
    report_o.crc_err <= crc_err_i;
end

endmodule

`default_nettype wire

// ==== csi2_rx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_rx_top
(
  input  logic                  clk_i,
  input  logic                  srst_i,
  input  csi2_pkg::lane_word_t  word_i,
  output logic                  report_valid_o,
  output csi2_pkg::pkt_report_t report_o
);

csi2_pkg::lane_word_t hdr_word;
logic                 ecc_err;
logic                 ecc_corrected;
logic                 payload;
logic                 crc_word;
logic                 crc_done;
logic                 crc_err;
logic                 pkt_done;

csi2_hamming_dec hamming_dec_i (
  .clk_i           ( clk_i          ),
  .srst_i          ( srst_i         ),
  .word_i          ( word_i         ),
  .pkt_done_i      ( pkt_done       ),
  .hdr_word_o      ( hdr_word       ),
  .err_o           ( ecc_err        ),
  .corrected_o     ( ecc_corrected  )
);

// runs beside the decoder on the raw stream.
csi2_crc_chk crc_chk_i (
  .clk_i           ( clk_i          ),
  .srst_i          ( srst_i         ),
  .word_i          ( word_i         ),
  .payload_i       ( payload        ),
  .crc_word_i      ( crc_word       ),
  .pkt_done_i      ( pkt_done       ),
  .crc_done_o      ( crc_done       ),
  .crc_err_o       ( crc_err        )
);

csi2_pkt_tracker pkt_tracker_i (
  .clk_i           ( clk_i          ),
  .srst_i          ( srst_i         ),
  .word_i          ( word_i         ),
  .hdr_word_i      ( hdr_word       ),
  .ecc_err_i       ( ecc_err        ),
  .ecc_corrected_i ( ecc_corrected  ),
  .crc_done_i      ( crc_done       ),
  .crc_err_i       ( crc_err        ),
  .payload_o       ( payload        ),
  .crc_word_o      ( crc_word       ),
  .pkt_done_o      ( pkt_done       ),
  .report_valid_o  ( report_valid_o ),
  .report_o        ( report_o       )
);

endmodule

`default_nettype wire

// ==== csi2_rx_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_rx_props
(
  input logic                 clk_i,
  input logic                 srst_i,
  input logic                 report_valid_i,
  input logic                 pkt_done_i,
  input logic                 payload_i,
  input logic                 crc_word_i,
  input logic                 crc_done_i,
  input logic [13:0]          words_left_i,
  input csi2_pkg::trk_state_t state_i
);

report_single: assert property (@(posedge clk_i) disable iff (srst_i)
  report_valid_i |=> !report_valid_i)
  else $error("report_valid_o high two cycles in a row");

// the crc result arrives while the tracker waits for it, and the packet ends next.
done_after_crc: assert property (@(posedge clk_i) disable iff (srst_i)
  crc_done_i |-> state_i == csi2_pkg::CRC_WORD ##1 pkt_done_i)
  else $error("pkt_done_o did not follow crc_done_i in CRC_WORD");

payload_counted: assert property (@(posedge clk_i) disable iff (srst_i)
  payload_i |-> words_left_i != 14'd0)
  else $error("payload_o high with no payload words left");

// crc word only once every payload word is counted.
crc_after_payload: assert property (@(posedge clk_i) disable iff (srst_i)
  crc_word_i |-> words_left_i == 14'd0)
  else $error("crc_word_o high before the payload count ran out");

endmodule

bind csi2_pkt_tracker csi2_rx_props rx_props_i (
  .clk_i          ( clk_i          ),
  .srst_i         ( srst_i         ),
  .report_valid_i ( report_valid_o ),
  .pkt_done_i     ( pkt_done_o     ),
  .payload_i      ( payload_o      ),
  .crc_word_i     ( crc_word_o     ),
  .crc_done_i     ( crc_done_i     ),
  .words_left_i   ( words_left     ),
  .state_i        ( state          )
);

`default_nettype wire

// ==== csi2_rx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csi2_rx_tb;

logic                  clk_i;
logic                  srst_i;
csi2_pkg::lane_word_t  word_i;
logic                  report_valid_o;
csi2_pkg::pkt_report_t report_o;
csi2_pkg::pkt_report_t exp_q[$];
integer                seed;
int                    errors;
int                    n_sent;
int                    n_reports = 0;
logic                  timed_out;
string                 test_name[7] = '{"clean", "hdr_data_flip", "ecc_bit_flip",
                                        "double_flip", "payload_corrupt", "crc_corrupt",
                                        "mixed"};

csi2_rx_top csi2_rx_top_i (
  .clk_i          ( clk_i          ),
  .srst_i         ( srst_i         ),
  .word_i         ( word_i         ),
  .report_valid_o ( report_valid_o ),
  .report_o       ( report_o       )
);

initial
begin
  clk_i = 1'b0;
  forever #4 clk_i = ~clk_i;
end

always @(negedge clk_i)
begin
  if (report_valid_o)
    n_reports++;                // every report, expected or not.
end

function automatic logic [5:0] ecc_calc(input logic [23:0] d);
  logic [5:0] p;
  for (int k = 0; k < 6; k++)
    p[k] = ^(d & csi2_pkg::ECC_PAR_MASK[k]);
  return p;
endfunction

// one byte into the reflected crc, lsb first.
function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [7:0] b);
  logic [15:0] r;
  r = c ^ {8'h00, b};
  for (int i = 0; i < 8; i++)
    r = r[0] ? ((r >> 1) ^ csi2_pkg::CRC_POLY_REFL) : (r >> 1);
  return r;
endfunction

task automatic drive_word(input logic valid, input logic [31:0] data);
  @(negedge clk_i);
  word_i.valid = valid;
  word_i.data  = data;
endtask

task automatic check_field(input string name, input logic [15:0] got,
                           input logic [15:0] want);
  if (got !== want)
  begin
    $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, want);
    errors++;
  end
endtask

task automatic wait_report(output int cyc);
  csi2_pkg::pkt_report_t want;
  cyc = 0;
  while (!report_valid_o && cyc < 64)
  begin
    drive_word(1'b0, $random(seed));
    cyc++;
  end
  if (!report_valid_o)
  begin
    $display("no report within 64 cycles of the last packet word");
    timed_out = 1'b1;
  end
  else
  begin
    want = exp_q.pop_front();
    check_field("report_o.vc", report_o.vc, want.vc);
    check_field("report_o.dt", report_o.dt, want.dt);
    check_field("report_o.wc", report_o.wc, want.wc);
    check_field("report_o.is_long", report_o.is_long, want.is_long);
    check_field("report_o.ecc_err", report_o.ecc_err, want.ecc_err);
    check_field("report_o.ecc_corrected", report_o.ecc_corrected, want.ecc_corrected);
    check_field("report_o.crc_err", report_o.crc_err, want.crc_err);
  end
endtask

// kind 0 clean, 1 header data bit, 2 ecc bit, 3 two ecc bits, 4 payload, 5 crc word.
task automatic send_packet(input int kind);
  logic [1:0]            vc;
  logic [5:0]            dt;
  logic [15:0]           wc;
  logic [29:0]           hdr;
  logic [31:0]           data;
  logic [15:0]           crc;
  csi2_pkg::pkt_report_t want;
  int                    flip;
  int                    e1;
  int                    e2;
  int                    bad;
  int                    cyc;
  vc   = 2'($random(seed));
  dt   = 6'($random(seed));
  wc   = 16'(4 * (1 + $unsigned($random(seed)) % 16));
  flip = $unsigned($random(seed)) % 24;
  e1   = $unsigned($random(seed)) % 6;
  e2   = (e1 + 1 + $unsigned($random(seed)) % 5) % 6;
  if (kind >= 4)
    dt[4] = 1'b1;               // crc faults need a long packet.
  hdr = {ecc_calc({wc, vc, dt}), wc, vc, dt};
  if (kind == 1)
    hdr[flip] = ~hdr[flip];
  if (kind == 2 || kind == 3)
    hdr[24 + e1] = ~hdr[24 + e1];
  if (kind == 3)
  begin
    hdr[24 + e2] = ~hdr[24 + e2];
    if (csi2_pkg::ecc_bit_pos(ecc_calc(hdr[23:0]) ^ hdr[29:24]) != 5'd31)
    begin
      $display("double ecc flip at bits %0d and %0d maps to a correctable error", e1, e2);
      errors++;
    end
  end
  want.vc            = vc;
  want.dt            = dt;
  want.wc            = wc;
  want.is_long       = (dt >= csi2_pkg::LONG_DT_MIN);
  want.ecc_err       = (kind >= 1 && kind <= 3);
  want.ecc_corrected = (kind == 1 || kind == 2);
  want.crc_err       = want.is_long && kind >= 4;
  exp_q.push_back(want);
  n_sent++;
  drive_word(1'b1, {2'b00, hdr});
  if (!want.is_long)
  begin
    wait_report(cyc);
    if (!timed_out && cyc != 3)
    begin
      $display("[FAIL] %0t short report latency got %0d expected 3", $time, cyc);
      errors++;
    end
  end
  else
  begin
    repeat (2) drive_word(1'b0, $random(seed));
    crc = csi2_pkg::CRC_INIT;
    bad = $unsigned($random(seed)) % (wc / 4);
    for (int w = 0; w < wc / 4; w++)
    begin
      data = $random(seed);
      for (int b = 0; b < 4; b++)
        crc = crc_byte(crc, data[8*b +: 8]);
      if (kind == 4 && w == bad)
        data[flip] = ~data[flip]; // corrupted after the crc was formed.
      repeat ($unsigned($random(seed)) % 3) drive_word(1'b0, $random(seed));
      drive_word(1'b1, data);
    end
    if (kind == 5)
      crc[flip % 16] = ~crc[flip % 16];
    drive_word(1'b1, {16'($random(seed)), crc});
    wait_report(cyc);
  end
  repeat (2) drive_word(1'b0, $random(seed));
endtask

initial
begin
  int errs_at;
  int sent_at;
  int kind;
  seed      = 32'hadec2c45;
  errors    = 0;
  n_sent    = 0;
  timed_out = 1'b0;
  word_i    = '0;
  srst_i    = 1'b1;
  repeat (5) @(negedge clk_i);
  srst_i = 1'b0;
  repeat (2) @(negedge clk_i);
  for (int t = 0; t < 7 && !timed_out; t++)
  begin
    errs_at = errors;
    sent_at = n_sent;
    for (int i = 0; i < 12 && !timed_out; i++)
    begin
      kind = (t == 6) ? $unsigned($random(seed)) % 6 : t;
      send_packet(kind);
      if (kind != 0 && !timed_out)
        send_packet(0);         // flags must be clear again.
    end
    $display("test %s: %0d packets, %0d errors", test_name[t], n_sent - sent_at,
             errors - errs_at);
  end
  repeat (4) @(negedge clk_i);
  if (n_reports != n_sent)
  begin
    $display("[FAIL] %0t report count got %0d expected %0d", $time, n_reports, n_sent);
    errors++;
  end
  $display("packets %0d, reports %0d, errors %0d", n_sent, n_reports, errors);
  if (errors == 0 && !timed_out)
    $display("All checks passed");
  else
    $display("Checks failed");
  $finish;
end

endmodule

`default_nettype wire

// ==== list.f ====
csi2_pkg.sv
csi2_hamming_dec.sv
csi2_crc_chk.sv
csi2_pkt_tracker.sv
csi2_rx_top.sv
csi2_rx_props.sv
csi2_rx_tb.sv
